// File: logic/order_config.svh
`ifndef ORDER_CONFIG_SVH
`define ORDER_CONFIG_SVH

// ====================
// Request fields
// ====================

// Byte address of a memory request
`define ADDR_W 32
// Write payload width
`define DATA_W 32

// ====================
// Filters and queues
// ====================

// Hashed address regions tracked by each filter
`define N_BUCKETS 16
// Counter width per bucket, top bit doubles as the full flag
`define BUCKET_BITS 4
// Requests waiting ahead of the gate
`define REQ_DEPTH 4
// Requests issued and not yet completed
`define INFLIGHT_DEPTH 8

`endif

// File: logic/mem_req_pkg.sv
`include "order_config.svh"

package mem_req_pkg;

    // ====================
    // Request kind
    // ====================

    // Reads may share a bucket
    // Writes need the bucket to themselves
    typedef enum logic
    {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_t;

    // ====================
    // Request record
    // ====================

    // One queued memory operation, kind in the top bit
    typedef struct packed
    {
        req_kind_t           kind;
        logic [`ADDR_W-1:0]  addr;
        // Don't care for reads, carried anyway
        logic [`DATA_W-1:0]  data;
    } mem_req_t;

endpackage

// File: logic/filter_pkg.sv
`include "order_config.svh"

package filter_pkg;

    // Bits needed to name one bucket
    localparam int BUCKET_IDX_W = $clog2(`N_BUCKETS);

    // Bucket index into the counting filters
    typedef logic [BUCKET_IDX_W-1:0] bucket_t;

    // What a completion must undo
    typedef struct packed
    {
        bucket_t                 bucket;
        mem_req_pkg::req_kind_t  kind;
    } inflight_t;

    // Fold an address into a bucket index
    // Bits 1:0 are byte offsets within a word and are dropped
    function automatic bucket_t addr_fold(input logic [`ADDR_W-1:0] addr);
        bucket_t             fold;
        logic [`ADDR_W-1:0]  rest;
        fold = '0;
        rest = addr >> 2;
        // XOR every nibble above the word offset, a partial top nibble pads with zeros
        for (int i = 0; i < `ADDR_W - 2; i += BUCKET_IDX_W)
        begin
            fold ^= rest[BUCKET_IDX_W-1:0];
            rest = rest >> BUCKET_IDX_W;
        end
        return fold;
    endfunction

endpackage

// File: logic/filter_if.sv
// One test, one insert and one remove port of a counting filter
interface filter_if;
    import filter_pkg::*;

    // Test port, answered in the same cycle
    bucket_t  test_bucket;
    // Counter has headroom for one more insert
    logic     not_full;
    // No entry outstanding in the tested bucket
    logic     is_zero;

    // Insert port, takes effect at the next edge
    bucket_t  insert_bucket;
    logic     insert_en;

    // Remove port, same timing as insert
    bucket_t  remove_bucket;
    logic     remove_en;

    // Filter side
    modport filter
    (
        input  test_bucket, insert_bucket, insert_en, remove_bucket, remove_en,
        output not_full, is_zero
    );

    // Requester side
    modport gate
    (
        output test_bucket, insert_bucket, insert_en, remove_bucket, remove_en,
        input  not_full, is_zero
    );

endinterface

// File: logic/counting_filter.sv
`include "order_config.svh"

// Counting filter, one counter per hashed bucket
module counting_filter
#(
    // Buckets held, must match the bucket index type
    parameter int N_BUCKETS   = `N_BUCKETS,
    // Counter width per bucket
    parameter int BUCKET_BITS = `BUCKET_BITS
)
(
    input  logic     clk,
    input  logic     reset_n,
    filter_if.filter flt
);

    // Outstanding entries per bucket
    logic [BUCKET_BITS-1:0] counters [N_BUCKETS];

    // ====================
    // Test logic
    // ====================

    // Headroom is judged by the top bit alone
    // Costs half the counter range, saves an adder on the test path
    assign flt.not_full = !counters[flt.test_bucket][BUCKET_BITS-1];

    assign flt.is_zero = (counters[flt.test_bucket] == BUCKET_BITS'(0));

    // ====================
    // Update logic
    // ====================

    // Each bucket matches itself against the two request ports
    for (genvar b = 0; b < N_BUCKETS; b++)
    begin : g_bucket
        logic up;
        logic down;

        // Hit on the insert port
        assign up = flt.insert_en && (flt.insert_bucket == b);

        // Hit on the remove port
        assign down = flt.remove_en && (flt.remove_bucket == b);

        // Insert and remove on one bucket cancel
        always_ff @(posedge clk)
        begin
            if (!reset_n)
            begin
                counters[b] <= BUCKET_BITS'(0);
            end
            else
            begin
                counters[b] <= counters[b] +
                               BUCKET_BITS'(up) -
                               BUCKET_BITS'(down);
            end
        end
    end

    // ====================
    // Checks
    // ====================

    // A remove must match an earlier insert on the same bucket
    // Only a same-cycle insert may cover an empty counter
    property p_no_underflow;
        @(posedge clk) disable iff (!reset_n)
        (flt.remove_en &&
         !(flt.insert_en && (flt.insert_bucket == flt.remove_bucket)))
            |-> (counters[flt.remove_bucket] != BUCKET_BITS'(0));
    endproperty

    a_no_underflow: assert property (p_no_underflow)
        else $error("counting_filter: remove on empty bucket %0d", flt.remove_bucket);

    // An insert never wraps a counter
    // The requester must have seen not_full on this bucket
    property p_no_overflow;
        @(posedge clk) disable iff (!reset_n)
        (flt.insert_en && !flt.remove_en)
            |-> (counters[flt.insert_bucket] != {BUCKET_BITS{1'b1}});
    endproperty

    a_no_overflow: assert property (p_no_overflow)
        else $error("counting_filter: insert on saturated bucket %0d", flt.insert_bucket);

endmodule

// File: logic/order_fifo.sv
// In-order queue with a type-parameter payload
module order_fifo
#(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
)
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);

    // Pointer and occupancy widths
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // ====================
    // Storage
    // ====================

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // Oldest entry is always presented
    assign pop_data = mem[rd_ptr];

    assign empty = (count == CNT_W'(0));
    assign full  = (count == CNT_W'(DEPTH));

    // Data written on push, never cleared
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ====================
    // Pointers
    // ====================

    // Wrap at DEPTH, depth need not be a power of two
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Push and pop together leave the count unchanged
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // ====================
    // Checks
    // ====================

    // Writer must respect full
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n) push |-> !full)
        else $error("order_fifo: push while full");

    // Reader must respect empty
    a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n) pop |-> !empty)
        else $error("order_fifo: pop while empty");

endmodule

// File: logic/hazard_gate.sv
`include "order_config.svh"

// Issue decision for the queue head against the read and write filters
module hazard_gate
(
    input  logic                   clk,
    input  logic                   reset_n,

    // Input queue head
    input  mem_req_pkg::mem_req_t  head,
    input  logic                   head_empty,
    output logic                   head_pop,

    // In-flight record queue
    input  logic                   inflight_full,
    output logic                   inflight_push,
    output filter_pkg::inflight_t  inflight_rec,
    input  filter_pkg::inflight_t  oldest,
    input  logic                   done_en,
    output logic                   inflight_pop,

    // Outstanding reads and writes per bucket
    filter_if.gate                 rd_flt,
    filter_if.gate                 wr_flt,

    // Issued request, registered
    output logic                   out_en,
    output logic [`ADDR_W-1:0]     out_addr,
    output logic [`DATA_W-1:0]     out_data,
    output mem_req_pkg::req_kind_t out_kind
);
    import mem_req_pkg::*;
    import filter_pkg::*;

    // Wide enough to count every in-flight slot
    localparam int CNT_W = $clog2(`INFLIGHT_DEPTH + 1);

    bucket_t          head_bucket;
    logic             head_is_write;
    logic             can_write;
    logic             can_read;
    logic             issue;
    logic [CNT_W-1:0] inflight_cnt;

    // ====================
    // Head test
    // ====================

    assign head_bucket   = addr_fold(head.addr);
    assign head_is_write = (head.kind == REQ_WRITE);

    // Both filters look at the head bucket
    assign rd_flt.test_bucket = head_bucket;
    assign wr_flt.test_bucket = head_bucket;

    // Write needs the bucket idle
    assign can_write = rd_flt.is_zero && wr_flt.is_zero;

    // Read only fears writes, plus room in its own counter
    assign can_read = wr_flt.is_zero && rd_flt.not_full;

    // A blocked head holds everything behind it
    assign issue = !head_empty && !inflight_full &&
                   (head_is_write ? can_write : can_read);

    // ====================
    // Issue side effects
    // ====================

    assign head_pop      = issue;
    assign inflight_push = issue;
    assign inflight_rec  = '{bucket: head_bucket, kind: head.kind};

    // Count the issue in the filter of its kind
    assign rd_flt.insert_bucket = head_bucket;
    assign rd_flt.insert_en     = issue && !head_is_write;
    assign wr_flt.insert_bucket = head_bucket;
    assign wr_flt.insert_en     = issue && head_is_write;

    // ====================
    // Completion side
    // ====================

    // Completions arrive in issue order, so the oldest record is the one done
    assign inflight_pop = done_en;

    assign rd_flt.remove_bucket = oldest.bucket;
    assign rd_flt.remove_en     = done_en && (oldest.kind == REQ_READ);
    assign wr_flt.remove_bucket = oldest.bucket;
    assign wr_flt.remove_en     = done_en && (oldest.kind == REQ_WRITE);

    // ====================
    // Output registers
    // ====================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            out_en <= 1'b0;
        else
            out_en <= issue;
    end

    // Payload follows the head, held between issues
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            out_addr <= head.addr;
            out_data <= head.data;
            out_kind <= head.kind;
        end
    end

    // Issued minus completed, as seen by the downstream memory
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            inflight_cnt <= '0;
        else
            inflight_cnt <= inflight_cnt + CNT_W'(issue) - CNT_W'(done_en);
    end

    // Memory may only complete what was issued to it
    a_done_has_owner: assert property (@(posedge clk) disable iff (!reset_n)
        done_en |-> (inflight_cnt != CNT_W'(0)))
        else $error("hazard_gate: done_en with nothing in flight");

endmodule

// File: logic/ordering_unit.sv
`include "order_config.svh"

// Memory request ordering unit, top level
module ordering_unit
(
    input  logic                   clk,
    input  logic                   reset_n,

    // Request input, taken when in_full is low
    input  logic                   in_en,
    input  mem_req_pkg::req_kind_t in_kind,
    input  logic [`ADDR_W-1:0]     in_addr,
    input  logic [`DATA_W-1:0]     in_data,
    output logic                   in_full,

    // Issued requests toward memory
    output logic                   out_en,
    output mem_req_pkg::req_kind_t out_kind,
    output logic [`ADDR_W-1:0]     out_addr,
    output logic [`DATA_W-1:0]     out_data,

    // Completion strobe, in issue order
    input  logic                   done_en
);
    import mem_req_pkg::*;
    import filter_pkg::*;

    mem_req_t  in_req;
    mem_req_t  head;
    logic      req_push;
    logic      head_pop;
    logic      head_empty;

    inflight_t inflight_rec;
    inflight_t oldest;
    logic      inflight_push;
    logic      inflight_pop;
    logic      inflight_empty;
    logic      inflight_full;

    // Filter links between gate and counters
    filter_if rd_flt ();
    filter_if wr_flt ();

    // ====================
    // Input queue
    // ====================

    assign in_req   = '{kind: in_kind, addr: in_addr, data: in_data};
    // Requests offered while full are dropped by the queue
    assign req_push = in_en && !in_full;

    order_fifo #(.payload_t(mem_req_t), .DEPTH(`REQ_DEPTH)) req_q
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (req_push),
        .push_data (in_req),
        .pop       (head_pop),
        .pop_data  (head),
        .empty     (head_empty),
        .full      (in_full)
    );

    // ====================
    // In-flight tracking
    // ====================

    order_fifo #(.payload_t(inflight_t), .DEPTH(`INFLIGHT_DEPTH)) inflight_q
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (inflight_push),
        .push_data (inflight_rec),
        .pop       (inflight_pop),
        .pop_data  (oldest),
        .empty     (inflight_empty),
        .full      (inflight_full)
    );

    // Reads per bucket
    counting_filter #(.N_BUCKETS(`N_BUCKETS), .BUCKET_BITS(`BUCKET_BITS)) rd_filter
    (
        .clk     (clk),
        .reset_n (reset_n),
        .flt     (rd_flt)
    );

    // Writes per bucket
    counting_filter #(.N_BUCKETS(`N_BUCKETS), .BUCKET_BITS(`BUCKET_BITS)) wr_filter
    (
        .clk     (clk),
        .reset_n (reset_n),
        .flt     (wr_flt)
    );

    // ====================
    // Issue gate
    // ====================

    hazard_gate gate
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .head          (head),
        .head_empty    (head_empty),
        .head_pop      (head_pop),
        .inflight_full (inflight_full),
        .inflight_push (inflight_push),
        .inflight_rec  (inflight_rec),
        .oldest        (oldest),
        .done_en       (done_en),
        .inflight_pop  (inflight_pop),
        .rd_flt        (rd_flt),
        .wr_flt        (wr_flt),
        .out_en        (out_en),
        .out_addr      (out_addr),
        .out_data      (out_data),
        .out_kind      (out_kind)
    );

    // Filters and record queue drain together
    // An empty record queue means every counter is back at zero
    a_idle_filters: assert property (@(posedge clk) disable iff (!reset_n)
        (inflight_empty && !head_empty) |-> (rd_flt.is_zero && wr_flt.is_zero))
        else $error("ordering_unit: filter count left with no record in flight");

endmodule

// File: sim/tb_clock.sv
// Free-running clock and a synchronous reset pulse
module tb_clock
#(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 10
)
(
    output logic clk,
    output logic reset_n
);

    // First rising edge half a period in
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released just after an edge, like every other input
    initial
    begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;
    end

endmodule

// File: sim/tb_ordering_unit.sv
`include "order_config.svh"

module tb_ordering_unit;
    import mem_req_pkg::*;
    import filter_pkg::*;

    // ====================
    // Run length
    // ====================

    localparam int N_RANDOM = 60;
    localparam int N_BURST  = 4;
    localparam int N_FILL   = 12;
    localparam int N_REQS   = N_RANDOM + N_BURST + N_FILL + `N_BUCKETS;
    localparam int LIMIT    = 40 * N_REQS + 200;

    logic               clk;
    logic               reset_n;
    logic               in_en;
    req_kind_t          in_kind;
    logic [`ADDR_W-1:0] in_addr;
    logic [`DATA_W-1:0] in_data;
    logic               in_full;
    logic               out_en;
    req_kind_t          out_kind;
    logic [`ADDR_W-1:0] out_addr;
    logic [`DATA_W-1:0] out_data;
    logic               done_en;

    // Requests accepted and not yet seen at the output
    mem_req_t  sent_q[$];
    // Issued and not completed, as the model sees it
    inflight_t model_q[$];
    // Completion due cycles, oldest first
    int        due_q[$];
    int        model_rd[`N_BUCKETS];
    int        model_wr[`N_BUCKETS];
    int        issued;
    int        cycle;
    bit        hold_done;
    bit        done_seen;
    int        req_errors;
    int        count_errors;
    int        rule_errors;
    int        other_errors;
    logic [31:0] lfsr = 32'h9d13;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(10)) clock_gen
    (
        .clk     (clk),
        .reset_n (reset_n)
    );

    ordering_unit dut_i
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .in_en    (in_en),
        .in_kind  (in_kind),
        .in_addr  (in_addr),
        .in_data  (in_data),
        .in_full  (in_full),
        .out_en   (out_en),
        .out_kind (out_kind),
        .out_addr (out_addr),
        .out_data (out_data),
        .done_en  (done_en)
    );

    // ====================
    // Helpers
    // ====================

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Issue rule on per-bucket counts taken before the issuing edge
    function automatic bit may_issue(input req_kind_t kind, input int rd_cnt,
                                     input int wr_cnt, input int in_flight);
        if (in_flight >= `INFLIGHT_DEPTH)
            return 1'b0;
        if (kind == REQ_WRITE)
            return (rd_cnt == 0) && (wr_cnt == 0);
        // Read counter full once its top bit would be set
        return (wr_cnt == 0) && (rd_cnt < (1 << (`BUCKET_BITS - 1)));
    endfunction

    task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
        string got_s;
        string exp_s;
        if (got !== exp)
        begin
            req_errors++;
            got_s = $sformatf("kind %0d addr %h data %h", got.kind, got.addr, got.data);
            exp_s = $sformatf("kind %0d addr %h data %h", exp.kind, exp.addr, exp.data);
            $display("Error at %0t: %s got %s, expected %s", $time, name, got_s, exp_s);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            count_errors++;
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Called just after an edge, returns just after the accepting edge
    task automatic send_req(input req_kind_t kind, input logic [`ADDR_W-1:0] addr,
                            input logic [`DATA_W-1:0] data);
        while (in_full)
        begin
            @(posedge clk);
            #1;
        end
        in_en   = 1'b1;
        in_kind = kind;
        in_addr = addr;
        in_data = data;
        sent_q.push_back('{kind: kind, addr: addr, data: data});
        @(posedge clk);
        #1;
        in_en = 1'b0;
    endtask

    // Bounded wait for the issue count
    task automatic wait_issued(input int target, input int limit);
        int n;
        n = 0;
        while (issued < target && n < limit)
        begin
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    // Everything sent has issued and completed, the cycle limit catches a hang
    task automatic drain();
        while (sent_q.size() != 0 || model_q.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // ====================
    // Memory model
    // ====================

    // Completions in issue order once the front is due
    always @(posedge clk)
    begin
        #1;
        if (!hold_done && due_q.size() > 0 && due_q[0] <= cycle)
        begin
            void'(due_q.pop_front());
            done_en = 1'b1;
        end
        else
        begin
            done_en = 1'b0;
        end
    end

    // ====================
    // Output monitor
    // ====================

    // Outputs are stable mid-cycle
    always @(negedge clk)
    begin : monitor
        mem_req_t  got;
        inflight_t rec;
        bucket_t   b;
        if (reset_n)
        begin
            if (out_en)
            begin
                got = '{kind: out_kind, addr: out_addr, data: out_data};
                b = addr_fold(got.addr);
                if (sent_q.size() == 0)
                begin
                    other_errors++;
                    $display("Error at %0t: request issued with none pending", $time);
                end
                else
                begin
                    check_req("out_req", got, sent_q.pop_front());
                end
                // Counts still reflect the state before the issuing edge
                if (!may_issue(got.kind, model_rd[b], model_wr[b], model_q.size()))
                begin
                    rule_errors++;
                    $display("Error at %0t: kind %0d issued to blocked bucket %0d",
                             $time, got.kind, b);
                    $display("Error at %0t: %0d reads, %0d writes, %0d in flight",
                             $time, model_rd[b], model_wr[b], model_q.size());
                end
            end
            // Completion taken at the same edge
            if (done_seen)
            begin
                rec = model_q.pop_front();
                if (rec.kind == REQ_WRITE)
                    model_wr[rec.bucket]--;
                else
                    model_rd[rec.bucket]--;
            end
            if (out_en)
            begin
                model_q.push_back('{bucket: b, kind: got.kind});
                if (got.kind == REQ_WRITE)
                    model_wr[b]++;
                else
                    model_rd[b]++;
                issued++;
                due_q.push_back(cycle + int'(rand_bits(3)) + 1);
            end
        end
        // Sampled by the DUT at the next edge
        done_seen = done_en;
    end

    // ====================
    // Timeout
    // ====================

    initial
    begin
        cycle = 0;
        while (cycle < LIMIT)
        begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    // ====================
    // Stimulus
    // ====================

    initial
    begin : stimulus
        int                 base;
        int                 n;
        logic [`ADDR_W-1:0] addr;
        req_kind_t          kind;
        in_en   = 1'b0;
        in_kind = REQ_READ;
        in_addr = '0;
        in_data = '0;
        done_en = 1'b0;
        hold_done = 1'b0;
        @(posedge clk iff reset_n);
        #1;

        // Idle after reset
        check_count("out_en", int'(out_en), 0);
        check_count("in_full", int'(in_full), 0);

        // Mixed traffic over eight buckets
        for (int i = 0; i < N_RANDOM; i++)
        begin
            kind = rand_bits(1) ? REQ_WRITE : REQ_READ;
            // Word index first, then the byte offset
            addr = rand_bits(3) << 2;
            addr = addr | rand_bits(2);
            send_req(kind, addr, rand_bits(32));
        end
        drain();

        // Read burst to one address overlaps
        hold_done = 1'b1;
        base = issued;
        addr = 32'h0000_0040;
        for (int i = 0; i < N_BURST; i++)
            send_req(REQ_READ, addr, 32'h0000_0100 + i);
        wait_issued(base + N_BURST, 40);
        check_count("reads in flight", model_rd[addr_fold(addr)], N_BURST);
        hold_done = 1'b0;
        drain();

        // Fill in-flight tracking, then the input queue
        hold_done = 1'b1;
        base = issued;
        for (int i = 0; i < N_FILL; i++)
            send_req(REQ_WRITE, `ADDR_W'(i) << 2, 32'h0000_0200 + i);
        n = 0;
        while (!in_full && n < 40)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        // Nothing more may leave while completions are held
        repeat (16) @(posedge clk);
        #1;
        check_count("requests in flight", issued - base, `INFLIGHT_DEPTH);
        check_count("in_full", int'(in_full), 1);
        hold_done = 1'b0;
        drain();

        // One write per bucket, needs every counter back at zero
        base = issued;
        for (int b = 0; b < `N_BUCKETS; b++)
            send_req(REQ_WRITE, `ADDR_W'(b) << 2, 32'hf000_0000 | b);
        wait_issued(base + `N_BUCKETS, 16 * `INFLIGHT_DEPTH);
        check_count("final writes issued", issued - base, `N_BUCKETS);
        drain();

        $display("Errors: %0d request, %0d count, %0d rule, %0d other",
                 req_errors, count_errors, rule_errors, other_errors);
        if (req_errors + count_errors + rule_errors + other_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: all.f
+incdir+logic
logic/mem_req_pkg.sv
logic/filter_pkg.sv
logic/filter_if.sv
logic/counting_filter.sv
logic/order_fifo.sv
logic/hazard_gate.sv
logic/ordering_unit.sv
sim/tb_clock.sv
sim/tb_ordering_unit.sv
